// File: bench/tb_nts_dispatcher.sv
`timescale 1ns/1ns
// --------------------
// Testbench for the NTS receive dispatcher:
// table-driven frames, packet readout and API checks
// --------------------
module tb_nts_dispatcher
  import nts_disp_pkg::*;
();

  typedef struct packed {
    logic [7:0] words;
    mask_t      last_mask;
    logic       good;
    logic [9:0] nbytes;  // Expected payload bytes
  } frame_t;

  localparam int NUM_FRAMES = 8;
  localparam frame_t FRAMES [NUM_FRAMES] = '{
    '{8'd4, 8'hff, 1'b1, 10'd32},
    '{8'd1, 8'hff, 1'b1, 10'd8},
    '{8'd6, 8'h0f, 1'b1, 10'd44},
    '{8'd5, 8'hff, 1'b0, 10'd40},
    '{8'd3, 8'h01, 1'b1, 10'd17},
    '{8'd2, 8'h7f, 1'b0, 10'd15},
    '{8'd7, 8'h3f, 1'b1, 10'd54},
    '{8'd8, 8'hff, 1'b1, 10'd64}
  };

  localparam logic [15:0] LFSR_SEED = 16'd13134;
  localparam logic [63:0] EXP_NAME = "NTS-DISP";
  localparam logic [31:0] EXP_VERSION = "0.02";
  localparam api_data_t EXP_SIGNATURE = 32'hf005_ba11;

  logic       clk;
  logic       areset;
  mask_t      rx_data_valid;
  data_word_t rx_data;
  logic       rx_good;
  logic       rx_bad;
  logic       packet_available;
  logic       discard;
  buf_addr_t  dispatch_counter;
  mask_t      dispatch_data_valid;
  logic       fifo_empty;
  logic       rd_start;
  logic       rd_valid;
  data_word_t rd_data;
  logic       api_cs;
  logic       api_we;
  api_addr_t  api_address;
  api_data_t  api_write_data;
  api_data_t  api_read_data;

  logic [15:0] lfsr_state;
  data_word_t  expected_words [$];
  int          starts_issued;
  int          cycle_count = 0;
  int          cycle_limit;

  nts_dispatcher u_nts_dispatcher (
    .i_clk                          (clk),
    .i_areset                       (areset),
    .i_rx_data_valid                (rx_data_valid),
    .i_rx_data                      (rx_data),
    .i_rx_good_frame                (rx_good),
    .i_rx_bad_frame                 (rx_bad),
    .o_dispatch_packet_available    (packet_available),
    .i_dispatch_packet_read_discard (discard),
    .o_dispatch_counter             (dispatch_counter),
    .o_dispatch_data_valid          (dispatch_data_valid),
    .o_dispatch_fifo_empty          (fifo_empty),
    .i_dispatch_fifo_rd_start       (rd_start),
    .o_dispatch_fifo_rd_valid       (rd_valid),
    .o_dispatch_fifo_rd_data        (rd_data),
    .i_api_cs                       (api_cs),
    .i_api_we                       (api_we),
    .i_api_address                  (api_address),
    .i_api_write_data               (api_write_data),
    .o_api_read_data                (api_read_data)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // --------------------
  // Helpers
  // --------------------
  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  function automatic logic [63:0] random_bits(input int nbits);
    logic [63:0] value;
    value = '0;
    for (int i = 0; i < nbits; i++)
      value = {value[62:0], lfsr_bit()};
    return value;
  endfunction

  // Low n bytes of the MAC word end up in the top n lanes
  function automatic data_word_t align_last(input data_word_t raw, input mask_t mask);
    data_word_t result;
    int n;
    n = 0;
    for (int i = 0; i < MASK_W; i++)
      if (mask[i])
        n++;
    result = '0;
    for (int i = 0; i < n; i++)
      result[8*(MASK_W-n+i) +: 8] = raw[8*i +: 8];
    return result;
  endfunction

  function automatic int timeout_cycles();
    int total;
    total = 200;
    for (int i = 0; i < NUM_FRAMES; i++)
      total += int'(FRAMES[i].words) + 40;
    return total;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input data_word_t exp, input data_word_t act);
    if (act !== exp)
      abort_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_mask(input string name, input mask_t exp, input mask_t act);
    if (act !== exp)
      abort_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_addr(input string name, input buf_addr_t exp, input buf_addr_t act);
    if (act !== exp)
      abort_run($sformatf("ERROR %s: expected %0d, actual %0d", name, exp, act));
  endtask

  task automatic check_api(input string name, input api_data_t exp, input api_data_t act);
    if (act !== exp)
      abort_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // Run limit
  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= cycle_limit)
      abort_run($sformatf("Timeout after %0d cycles, the DUT stopped responding", cycle_count));
  end

  // --------------------
  // MAC and consumer side
  // --------------------
  task automatic send_frame(input frame_t f);
    data_word_t raw;
    expected_words.delete();
    rx_data_valid = '0;  // Idle cycle ahead of sof
    rx_data       = '0;
    next_cycle();
    for (int w = 0; w < int'(f.words); w++)
    begin
      raw     = random_bits(DATA_W);
      rx_data = raw;
      if (w == int'(f.words) - 1)
      begin
        rx_data_valid = f.last_mask;
        rx_good       = f.good;
        rx_bad        = !f.good;
        expected_words.push_back(align_last(raw, f.last_mask));
      end
      else
      begin
        rx_data_valid = '1;
        expected_words.push_back(raw);
      end
      next_cycle();
    end
    rx_data_valid = '0;
    rx_data       = '0;
    rx_good       = 1'b0;
    rx_bad        = 1'b0;
  endtask

  task automatic read_packet(input string name, input frame_t f);
    int waited;
    int latency;
    int count;
    waited = 0;
    while (!packet_available)
    begin
      next_cycle();
      waited++;
      if (waited > 20)
        abort_run($sformatf("%s: packet_available never went high", name));
    end
    check_addr({name, " counter"}, buf_addr_t'(int'(f.words) - 1), dispatch_counter);
    check_mask({name, " data_valid"}, f.last_mask, dispatch_data_valid);

    rd_start = 1'b1;
    starts_issued++;
    next_cycle();
    rd_start = 1'b0;
    latency  = 1;
    while (!rd_valid)
    begin
      next_cycle();
      latency++;
      if (latency > 10)
        abort_run($sformatf("%s: rd_valid never went high after rd_start", name));
    end
    if (latency != 2)
      abort_run($sformatf("ERROR %s latency: expected 2, actual %0d", name, latency));

    count = 0;
    while (rd_valid)
    begin
      if (count >= expected_words.size())
        abort_run($sformatf("%s: rd_valid stayed high past the last word", name));
      check_word($sformatf("%s word %0d", name, count), expected_words[count], rd_data);
      count++;
      next_cycle();
    end
    check_addr({name, " rd_valid cycles"}, buf_addr_t'(int'(f.words) - 1),
               buf_addr_t'(count - 1));
    if (!fifo_empty)
      abort_run($sformatf("%s: fifo_empty low after the packet ended", name));

    discard = 1'b1;  // Release the buffer
    next_cycle();
    discard = 1'b0;
  endtask

  task automatic expect_no_packet(input string name);
    for (int i = 0; i < 6; i++)
    begin
      if (packet_available)
        abort_run($sformatf("%s: packet_available rose for a bad frame", name));
      next_cycle();
    end
  endtask

  // --------------------
  // Register API
  // --------------------
  task automatic api_read(input api_addr_t addr, output api_data_t data);
    api_cs      = 1'b1;
    api_we      = 1'b0;
    api_address = addr;
    #1;
    data = api_read_data;  // Combinational read
    next_cycle();
    api_cs = 1'b0;
  endtask

  task automatic api_write(input api_addr_t addr, input api_data_t data);
    api_cs         = 1'b1;
    api_we         = 1'b1;
    api_address    = addr;
    api_write_data = data;
    next_cycle();
    api_cs = 1'b0;
    api_we = 1'b0;
  endtask

  task automatic check_counter(input string name, input api_addr_t msb_addr,
                               input stat_count_t exp);
    api_data_t hi;
    api_data_t lo;
    api_read(msb_addr, hi);
    api_read(msb_addr + 1'b1, lo);  // Latched by the MSB read
    check_api({name, " MSB"}, exp[63:32], hi);
    check_api({name, " LSB"}, exp[31:0], lo);
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial
  begin
    frame_t    f;
    string     name;
    api_data_t value;
    api_data_t rdata;
    int        bytes_total;
    int        good_total;
    int        bad_total;

    cycle_limit    = timeout_cycles();
    lfsr_state     = LFSR_SEED;
    starts_issued  = 0;
    bytes_total    = 0;
    good_total     = 0;
    bad_total      = 0;
    areset         = 1'b1;
    rx_data_valid  = '0;
    rx_data        = '0;
    rx_good        = 1'b0;
    rx_bad         = 1'b0;
    discard        = 1'b0;
    rd_start       = 1'b0;
    api_cs         = 1'b0;
    api_we         = 1'b0;
    api_address    = '0;
    api_write_data = '0;
    repeat (10) @(posedge clk);
    #1;
    areset = 1'b0;
    next_cycle();
    if (!fifo_empty || packet_available || rd_valid)
      abort_run("Dispatch outputs not idle after reset");

    api_read(ADDR_NAME0, rdata);
    check_api("name0", EXP_NAME[63:32], rdata);
    api_read(ADDR_NAME1, rdata);
    check_api("name1", EXP_NAME[31:0], rdata);
    api_read(ADDR_VERSION, rdata);
    check_api("version", EXP_VERSION, rdata);
    api_read(ADDR_LAST, rdata);
    check_api("signature", EXP_SIGNATURE, rdata);
    api_read(12'h100, rdata);
    check_api("unmapped", '0, rdata);
    value = api_data_t'(random_bits(API_DATA_W));
    api_write(ADDR_DUMMY, value);
    api_read(ADDR_DUMMY, rdata);
    check_api("dummy", value, rdata);

    for (int i = 0; i < NUM_FRAMES; i++)
    begin
      f    = FRAMES[i];
      name = $sformatf("frame %0d", i);
      send_frame(f);
      bytes_total += int'(f.nbytes);
      if (f.good)
      begin
        good_total++;
        read_packet(name, f);
      end
      else
      begin
        bad_total++;
        expect_no_packet(name);
      end
    end

    check_counter("frames", ADDR_CNT_FRAMES_MSB, stat_count_t'(NUM_FRAMES));
    check_counter("good", ADDR_CNT_GOOD_MSB, stat_count_t'(good_total));
    check_counter("bad", ADDR_CNT_BAD_MSB, stat_count_t'(bad_total));
    check_counter("dispatched", ADDR_CNT_DISPATCHED_MSB, stat_count_t'(starts_issued));
    check_counter("bytes", ADDR_BYTES_RX_MSB, stat_count_t'(bytes_total));

    $display("Simulation PASSED");
    $finish;
  end

endmodule

// File: hw/disp_stats_regs.sv
`timescale 1ns/1ns
// --------------------
// Statistics counters and API register decoder
// --------------------
module disp_stats_regs
  import nts_disp_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_areset,
  rx_word_if.sink   i_rx,
  input  logic      i_rd_start_seen,
  input  logic      i_api_cs,
  input  logic      i_api_we,
  input  api_addr_t i_api_address,
  input  api_data_t i_api_write_data,
  output api_data_t o_api_read_data
);

  stat_count_t            cnt     [NUM_STATS];
  api_data_t              cnt_lsb [NUM_STATS]; // Low half at last MSB read
  stat_count_t            inc     [NUM_STATS];
  logic [NUM_STATS-1:0]   lsb_we;
  api_data_t              dummy;
  api_data_t              read_data;

  always_comb
  begin
    inc[STAT_FRAMES]     = stat_count_t'(i_rx.sof);
    inc[STAT_GOOD]       = stat_count_t'(i_rx.good);
    inc[STAT_BAD]        = stat_count_t'(i_rx.bad);
    inc[STAT_DISPATCHED] = stat_count_t'(i_rd_start_seen);
    inc[STAT_BYTES]      = stat_count_t'(i_rx.nbytes);
  end

  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      dummy <= '0;
      for (int i = 0; i < NUM_STATS; i++)
      begin
        cnt[i]     <= '0;
        cnt_lsb[i] <= '0;
      end
    end
    else
    begin
      for (int i = 0; i < NUM_STATS; i++)
      begin
        cnt[i] <= cnt[i] + inc[i];
        if (lsb_we[i])
          cnt_lsb[i] <= cnt[i][31:0];
      end
      if (i_api_cs && i_api_we && (i_api_address == ADDR_DUMMY))
        dummy <= i_api_write_data;
    end
  end

  // --------------------
  // Read decoder
  // --------------------
  always_comb
  begin
    read_data = '0;  // Unmapped reads as zero
    lsb_we    = '0;
    if (i_api_cs && !i_api_we)
    begin
      case (i_api_address)
        ADDR_NAME0:   read_data = CORE_NAME[63:32];
        ADDR_NAME1:   read_data = CORE_NAME[31:0];
        ADDR_VERSION: read_data = CORE_VERSION;
        ADDR_DUMMY:   read_data = dummy;
        ADDR_BYTES_RX_MSB:
        begin
          read_data          = cnt[STAT_BYTES][63:32];
          lsb_we[STAT_BYTES] = 1'b1;
        end
        ADDR_BYTES_RX_LSB: read_data = cnt_lsb[STAT_BYTES];
        ADDR_CNT_FRAMES_MSB:
        begin
          read_data           = cnt[STAT_FRAMES][63:32];
          lsb_we[STAT_FRAMES] = 1'b1;
        end
        ADDR_CNT_FRAMES_LSB: read_data = cnt_lsb[STAT_FRAMES];
        ADDR_CNT_GOOD_MSB:
        begin
          read_data         = cnt[STAT_GOOD][63:32];
          lsb_we[STAT_GOOD] = 1'b1;
        end
        ADDR_CNT_GOOD_LSB: read_data = cnt_lsb[STAT_GOOD];
        ADDR_CNT_BAD_MSB:
        begin
          read_data        = cnt[STAT_BAD][63:32];
          lsb_we[STAT_BAD] = 1'b1;
        end
        ADDR_CNT_BAD_LSB: read_data = cnt_lsb[STAT_BAD];
        ADDR_CNT_DISPATCHED_MSB:
        begin
          read_data               = cnt[STAT_DISPATCHED][63:32];
          lsb_we[STAT_DISPATCHED] = 1'b1;
        end
        ADDR_CNT_DISPATCHED_LSB: read_data = cnt_lsb[STAT_DISPATCHED];
        ADDR_LAST:               read_data = END_SIGNATURE;
        default: ;
      endcase
    end
  end

  assign o_api_read_data = read_data;

endmodule

// File: hw/frame_buffers.sv
`timescale 1ns/1ns
// --------------------
// Ping-pong packet buffers: one captures from the MAC
// while the other streams out to the consumer
// --------------------
module frame_buffers
  import nts_disp_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_areset,
  rx_word_if.sink    i_rx,
  input  logic       i_rd_start,
  input  logic       i_discard,
  output logic       o_packet_available,
  output buf_addr_t  o_counter,
  output mask_t      o_data_valid,
  output logic       o_fifo_empty,
  output logic       o_rd_valid,
  output data_word_t o_rd_data,
  output logic       o_rd_start_seen
);

  logic       cur;             // Buffer capturing from the MAC
  logic       out_sel;         // Buffer facing the consumer
  buf_state_t state      [2];
  buf_addr_t  counter    [2];  // Index of last word
  mask_t      data_valid [2];  // Mask of last word
  logic       write      [2];
  data_word_t r_data     [2];
  buf_addr_t  w_addr;
  data_word_t w_data;
  buf_addr_t  r_addr;
  logic       rd_valid;
  logic       fifo_empty;
  logic       rd_accept;
  logic       cap_write;
  buf_addr_t  cap_addr;

  assign out_sel   = ~cur;
  assign rd_accept = (state[out_sel] == OUT_READY) && i_rd_start && !i_discard;

  // --------------------
  // Buffer RAMs
  // --------------------
  for (genvar g = 0; g < 2; g++)
  begin : g_buf
    packet_ram u_packet_ram (
      .i_clk   (i_clk),
      .i_addr  (write[g] ? w_addr : r_addr),
      .i_write (write[g]),
      .i_data  (w_data),
      .o_data  (r_data[g])
    );
  end

  // Where the incoming word goes, if anywhere
  always_comb
  begin
    cap_write = 1'b0;
    cap_addr  = '0;
    case (state[cur])
      EMPTY:
        cap_write = i_rx.sof;
      HAS_DATA:
        begin
          cap_write = (i_rx.valid_mask != '0) && (counter[cur] != '1); // Stop on overflow
          cap_addr  = counter[cur] + 1'b1;
        end
      default: ;
    endcase
  end

  always_ff @(posedge i_clk)
  begin
    if (cap_write)
      w_data <= i_rx.word;
  end

  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      cur        <= 1'b0;
      w_addr     <= '0;
      r_addr     <= '0;
      rd_valid   <= 1'b0;
      fifo_empty <= 1'b1;
      for (int i = 0; i < 2; i++)
      begin
        state[i]      <= EMPTY;
        counter[i]    <= '0;
        data_valid[i] <= '0;
        write[i]      <= 1'b0;
      end
    end
    else
    begin
      write[0]   <= 1'b0;
      write[1]   <= 1'b0;
      write[cur] <= cap_write;
      if (cap_write)
      begin
        w_addr       <= cap_addr;
        counter[cur] <= cap_addr;
      end

      // --------------------
      // Capture side
      // --------------------
      case (state[cur])
        EMPTY:
          if (i_rx.sof && !i_rx.bad)
          begin
            state[cur]      <= i_rx.good ? RECEIVED : HAS_DATA; // Single-word frame
            data_valid[cur] <= i_rx.valid_mask;
          end
        HAS_DATA:
          if (i_rx.bad)
            state[cur] <= EMPTY;
          else if (i_rx.good)
          begin
            state[cur]      <= RECEIVED;
            data_valid[cur] <= i_rx.valid_mask;
          end
        RECEIVED:
          if (state[out_sel] == EMPTY)
          begin
            state[cur] <= OUT_READY;
            cur        <= out_sel;   // Swap roles
          end
        default:
          state[cur] <= EMPTY;
      endcase

      // --------------------
      // Readout side
      // --------------------
      if (i_discard)
      begin
        state[out_sel] <= EMPTY;
        rd_valid       <= 1'b0;
        fifo_empty     <= 1'b1;
      end
      else
      begin
        case (state[out_sel])
          OUT_READY:
            if (rd_accept)
            begin
              state[out_sel] <= OUT_START;
              r_addr         <= '0;
            end
          OUT_START:
            begin
              rd_valid       <= 1'b1;  // Word 0 leaves the RAM next cycle
              fifo_empty     <= 1'b0;
              r_addr         <= buf_addr_t'(1);
              state[out_sel] <= (counter[out_sel] == '0) ? OUT_LAST : OUT_STREAM;
            end
          OUT_STREAM:
            if (r_addr == counter[out_sel])
              state[out_sel] <= OUT_LAST;
            else
              r_addr <= r_addr + 1'b1;
          OUT_LAST:
            begin
              rd_valid       <= 1'b0;
              fifo_empty     <= 1'b1;
              state[out_sel] <= OUT_DONE;
            end
          default: ;  // OUT_DONE holds until discard
        endcase
      end
    end
  end

  assign o_packet_available = state[out_sel] == OUT_READY;
  assign o_counter          = counter[out_sel];
  assign o_data_valid       = data_valid[out_sel];
  assign o_fifo_empty       = fifo_empty;
  assign o_rd_valid         = rd_valid;
  assign o_rd_data          = rd_valid ? r_data[out_sel] : '0;
  assign o_rd_start_seen    = rd_accept;

  // Streaming only ever follows an accepted start, two cycles on
  a_valid_after_start : assert property (
    @(posedge i_clk) disable iff (i_areset)
    $rose(rd_valid) |-> $past(rd_accept, 2)
  ) else $error("frame_buffers: rd_valid without accepted rd_start");

  a_one_output_buffer : assert property (
    @(posedge i_clk) disable iff (i_areset)
    !((state[0] >= OUT_READY) && (state[1] >= OUT_READY))
  ) else $error("frame_buffers: both buffers in output states");

endmodule

// File: hw/nts_disp_pkg.sv
// --------------------
// NTS dispatcher shared widths, API map,
// core identity and buffer states
// --------------------
package nts_disp_pkg;

  localparam int DATA_W     = 64;
  localparam int MASK_W     = 8;
  localparam int BUF_ADDR_W = 8;
  localparam int BUF_DEPTH  = 1 << BUF_ADDR_W;
  localparam int API_ADDR_W = 12;
  localparam int API_DATA_W = 32;

  typedef logic [DATA_W-1:0]     data_word_t;
  typedef logic [MASK_W-1:0]     mask_t;
  typedef logic [BUF_ADDR_W-1:0] buf_addr_t;
  typedef logic [API_ADDR_W-1:0] api_addr_t;
  typedef logic [API_DATA_W-1:0] api_data_t;
  typedef logic [63:0]           stat_count_t;
  typedef logic [3:0]            byte_count_t; // 0 to 8 bytes

  // --------------------
  // API register map
  // --------------------
  localparam api_addr_t ADDR_NAME0              = 12'h000;
  localparam api_addr_t ADDR_NAME1              = 12'h001;
  localparam api_addr_t ADDR_VERSION            = 12'h002;
  localparam api_addr_t ADDR_DUMMY              = 12'h003;
  localparam api_addr_t ADDR_BYTES_RX_MSB       = 12'h00a;
  localparam api_addr_t ADDR_BYTES_RX_LSB       = 12'h00b;
  localparam api_addr_t ADDR_CNT_FRAMES_MSB     = 12'h020;
  localparam api_addr_t ADDR_CNT_FRAMES_LSB     = 12'h021;
  localparam api_addr_t ADDR_CNT_GOOD_MSB       = 12'h022;
  localparam api_addr_t ADDR_CNT_GOOD_LSB       = 12'h023;
  localparam api_addr_t ADDR_CNT_BAD_MSB        = 12'h024;
  localparam api_addr_t ADDR_CNT_BAD_LSB        = 12'h025;
  localparam api_addr_t ADDR_CNT_DISPATCHED_MSB = 12'h026;
  localparam api_addr_t ADDR_CNT_DISPATCHED_LSB = 12'h027;
  localparam api_addr_t ADDR_LAST               = 12'hfff;

  localparam logic [63:0] CORE_NAME     = 64'h4e54_532d_4449_5350; // "NTS-DISP"
  localparam logic [31:0] CORE_VERSION  = 32'h302e_3032;           // "0.02"
  localparam api_data_t   END_SIGNATURE = 32'hf005_ba11;

  // Statistics counter slots
  localparam int STAT_FRAMES     = 0;
  localparam int STAT_GOOD       = 1;
  localparam int STAT_BAD        = 2;
  localparam int STAT_DISPATCHED = 3;
  localparam int STAT_BYTES      = 4;
  localparam int NUM_STATS       = 5;

  // Output states must stay at the top of the encoding
  typedef enum logic [2:0] {
    EMPTY, HAS_DATA, RECEIVED, OUT_READY, OUT_START, OUT_STREAM, OUT_LAST, OUT_DONE
  } buf_state_t;

endpackage

// File: hw/nts_dispatcher.sv
`timescale 1ns/1ns
// --------------------
// NTS receive dispatcher top level
// --------------------
module nts_dispatcher
  import nts_disp_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_areset,

  // MAC receive
  input  mask_t      i_rx_data_valid,
  input  data_word_t i_rx_data,
  input  logic       i_rx_good_frame,
  input  logic       i_rx_bad_frame,

  // Dispatch to consumer
  output logic       o_dispatch_packet_available,
  input  logic       i_dispatch_packet_read_discard,
  output buf_addr_t  o_dispatch_counter,
  output mask_t      o_dispatch_data_valid,
  output logic       o_dispatch_fifo_empty,
  input  logic       i_dispatch_fifo_rd_start,
  output logic       o_dispatch_fifo_rd_valid,
  output data_word_t o_dispatch_fifo_rd_data,

  // Register API
  input  logic       i_api_cs,
  input  logic       i_api_we,
  input  api_addr_t  i_api_address,
  input  api_data_t  i_api_write_data,
  output api_data_t  o_api_read_data
);

  logic rd_start_seen;

  rx_word_if u_rx_if ();

  rx_frontend u_rx_frontend (
    .i_clk           (i_clk),
    .i_areset        (i_areset),
    .i_rx_data_valid (i_rx_data_valid),
    .i_rx_data       (i_rx_data),
    .i_rx_good_frame (i_rx_good_frame),
    .i_rx_bad_frame  (i_rx_bad_frame),
    .o_rx            (u_rx_if)
  );

  frame_buffers u_frame_buffers (
    .i_clk              (i_clk),
    .i_areset           (i_areset),
    .i_rx               (u_rx_if),
    .i_rd_start         (i_dispatch_fifo_rd_start),
    .i_discard          (i_dispatch_packet_read_discard),
    .o_packet_available (o_dispatch_packet_available),
    .o_counter          (o_dispatch_counter),
    .o_data_valid       (o_dispatch_data_valid),
    .o_fifo_empty       (o_dispatch_fifo_empty),
    .o_rd_valid         (o_dispatch_fifo_rd_valid),
    .o_rd_data          (o_dispatch_fifo_rd_data),
    .o_rd_start_seen    (rd_start_seen)
  );

  disp_stats_regs u_disp_stats_regs (
    .i_clk            (i_clk),
    .i_areset         (i_areset),
    .i_rx             (u_rx_if),
    .i_rd_start_seen  (rd_start_seen),
    .i_api_cs         (i_api_cs),
    .i_api_we         (i_api_we),
    .i_api_address    (i_api_address),
    .i_api_write_data (i_api_write_data),
    .o_api_read_data  (o_api_read_data)
  );

endmodule

// File: hw/packet_ram.sv
`timescale 1ns/1ns
// --------------------
// One packet of 64-bit words, single port
// --------------------
module packet_ram
  import nts_disp_pkg::*;
(
  input  logic       i_clk,
  input  buf_addr_t  i_addr,
  input  logic       i_write,
  input  data_word_t i_data,
  output data_word_t o_data
);

  data_word_t mem [BUF_DEPTH];

  // Read-first, one cycle latency
  always_ff @(posedge i_clk)
  begin
    if (i_write)
      mem[i_addr] <= i_data;
    o_data <= mem[i_addr];
  end

endmodule

// File: hw/rx_frontend.sv
`timescale 1ns/1ns
// --------------------
// MAC receive front end: aligns the last word,
// counts its bytes and detects start of frame
// --------------------
module rx_frontend
  import nts_disp_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_areset,
  input  mask_t      i_rx_data_valid,
  input  data_word_t i_rx_data,
  input  logic       i_rx_good_frame,
  input  logic       i_rx_bad_frame,
  rx_word_if.source  o_rx
);

  mask_t       prev_mask;
  logic        contiguous;
  byte_count_t nbytes;

  // All ones, so a word already in flight at start-up is not a sof
  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
      prev_mask <= '1;
    else
      prev_mask <= i_rx_data_valid;
  end

  // Low ones only, i.e. mask & (mask+1) is zero
  assign contiguous = (i_rx_data_valid & mask_t'(i_rx_data_valid + 1'b1)) == '0;

  assign nbytes = contiguous ? byte_count_t'($countones(i_rx_data_valid)) : '0;

  // --------------------
  // Byte alignment
  // --------------------
  // Valid bytes move to the top lanes, matching the rest of the frame
  always_comb
  begin
    if (contiguous)
      o_rx.word = i_rx_data << (8 * (MASK_W - int'(nbytes))); // Zero mask gives zero
    else
      o_rx.word = i_rx_data;
  end

  assign o_rx.valid_mask = i_rx_data_valid;
  assign o_rx.nbytes     = nbytes;
  assign o_rx.sof        = (prev_mask == '0) && (i_rx_data_valid == '1); // Idle then full word
  assign o_rx.good       = i_rx_good_frame;
  assign o_rx.bad        = i_rx_bad_frame;

  // The MAC only ever sends low-aligned masks
  a_mask_contiguous : assert property (
    @(posedge i_clk) disable iff (i_areset)
    contiguous
  ) else $error("rx_frontend: non-contiguous byte mask %b", i_rx_data_valid);

endmodule

// File: hw/rx_word_if.sv
`timescale 1ns/1ns
// --------------------
// One pre-processed receive word
// --------------------
interface rx_word_if
  import nts_disp_pkg::*;
();

  mask_t       valid_mask; // Raw MAC mask
  data_word_t  word;       // Left-aligned data
  byte_count_t nbytes;
  logic        sof;
  logic        good;
  logic        bad;

  modport source (output valid_mask, word, nbytes, sof, good, bad);

  modport sink (input valid_mask, word, nbytes, sof, good, bad);

endinterface

// File: run_sim.sh
#!/usr/bin/env bash
# Build the NTS dispatcher testbench with Verilator and run it.
# The run passes only if the simulation prints its pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_nts_dispatcher -o tb_sim \
  && ./obj_dir/tb_sim 2>&1 | tee /dev/stderr | grep -q "^Simulation PASSED$" \
  && echo "Run passed" \
  || { echo "Run failed"; exit 1; }

// File: tb.f
hw/nts_disp_pkg.sv
hw/rx_word_if.sv
hw/rx_frontend.sv
hw/packet_ram.sv
hw/frame_buffers.sv
hw/disp_stats_regs.sv
hw/nts_dispatcher.sv
bench/tb_nts_dispatcher.sv
